//--- rv_ops_pkg.sv
package rv_ops_pkg;

    localparam int data_width = 32;
    localparam int shamt_bits = 5;
    localparam int reg_count  = 32;
    localparam int op_bits    = 6;

    typedef logic [data_width-1:0] data_t;
    typedef logic [4:0]            reg_idx_t;

    localparam reg_idx_t zero_reg = 5'd0;
    localparam data_t    pc_step  = 32'd4;

    // 38 codes, so six bits are needed
    typedef enum logic [op_bits-1:0] {
        op_nop,
        op_add, op_sub, op_and, op_or, op_xor, op_sll, op_srl, op_sra, op_sltu, op_slt,
        op_addi, op_andi, op_ori, op_xori, op_slli, op_srli, op_srai, op_sltiu, op_slti,
        op_lui, op_auipc, op_jal, op_jalr,
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        op_lw, op_lhu, op_lh, op_lbu, op_lb, op_sw, op_sh, op_sb
    } op_e;

    function automatic logic op_is_branch(input op_e op);
        return op inside {op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu};
    endfunction

    function automatic logic op_is_store(input op_e op);
        return op inside {op_sw, op_sh, op_sb};
    endfunction

    function automatic logic op_writes_rd(input op_e op);
        return !(op_is_branch(op) || op_is_store(op) || op == op_nop);
    endfunction

    function automatic logic op_uses_rs1(input op_e op);
        return !(op inside {op_nop, op_lui, op_auipc, op_jal});
    endfunction

    // loads carry rs2 through to ls_data as well
    function automatic logic op_uses_rs2(input op_e op);
        return op inside {[op_add:op_slt], [op_beq:op_sb]};
    endfunction

endpackage

//--- ooo_types_pkg.sv
package ooo_types_pkg;

    localparam int rob_tag_bits = 4;
    localparam int rs_depth     = 4;
    localparam int tag_pad_bits = rv_ops_pkg::data_width - rob_tag_bits;

    typedef logic [rob_tag_bits-1:0]     rob_tag_t;
    typedef logic [$clog2(rs_depth)-1:0] rs_idx_t;

    localparam rob_tag_t zero_tag  = 4'd0;
    localparam rob_tag_t first_tag = 4'd1;
    localparam rob_tag_t last_tag  = 4'd15;

    typedef struct packed {
        logic [tag_pad_bits-1:0] pad;
        rob_tag_t                tag;
    } tag_word_t;

    // value when ready, producer tag otherwise
    typedef union packed {
        rv_ops_pkg::data_t value;
        tag_word_t         pend;
    } operand_u;

    typedef struct packed {
        logic     ready;
        operand_u u;
    } operand_t;

    typedef struct packed {
        logic                 valid;
        rv_ops_pkg::op_e      op;
        rv_ops_pkg::reg_idx_t rd;
        rv_ops_pkg::reg_idx_t rs1;
        rv_ops_pkg::reg_idx_t rs2;
        rv_ops_pkg::data_t    imm;
        rv_ops_pkg::data_t    pc;
    } dispatch_t;

    typedef struct packed {
        logic              busy;
        rv_ops_pkg::op_e   op;
        rob_tag_t          tag;
        operand_t          opa;
        operand_t          opb;
        rv_ops_pkg::data_t imm;
        rv_ops_pkg::data_t pc;
    } rs_entry_t;

    typedef struct packed {
        logic              valid;
        rv_ops_pkg::op_e   op;
        rob_tag_t          tag;
        rv_ops_pkg::data_t a;
        rv_ops_pkg::data_t b;
        rv_ops_pkg::data_t imm;
        rv_ops_pkg::data_t pc;
    } issue_t;

    typedef struct packed {
        logic              valid;
        rob_tag_t          tag;
        rv_ops_pkg::data_t value;
        rv_ops_pkg::data_t ls_data;
        logic              jump_ena;
        rv_ops_pkg::data_t jump_addr;
    } cdb_t;

    // capture a broadcast value if this operand waits on its tag
    function automatic operand_t wake_operand(input operand_t opnd, input cdb_t bus);
        operand_t res;
        res = opnd;
        if (!opnd.ready && bus.valid && opnd.u.pend.tag == bus.tag) begin
            res.ready   = 1'b1;
            res.u.value = bus.value;
        end
        return res;
    endfunction

endpackage

//--- dispatch_rename.sv
`timescale 1ns/1ps

module dispatch_rename (
    input  logic                     clk,
    input  logic                     rst,
    input  ooo_types_pkg::dispatch_t dispatch,
    input  ooo_types_pkg::cdb_t      cdb,
    input  logic                     rs_full,
    output ooo_types_pkg::rs_entry_t rs_alloc
);
    import rv_ops_pkg::*;
    import ooo_types_pkg::*;

    // register status table
    operand_t rat [reg_count];
    rob_tag_t next_tag;

    logic accept;
    logic marks_rd;

    function automatic operand_t rename_src(
        input reg_idx_t idx,
        input logic     used,
        input operand_t cur,
        input cdb_t     bus
    );
        operand_t res;
        if (!used || idx == zero_reg) begin
            res.ready   = 1'b1;
            res.u.value = '0;
        end else begin
            // bypass from the bus, else table contents
            res = wake_operand(cur, bus);
        end
        return res;
    endfunction

    // nop takes no slot and no tag
    assign accept   = dispatch.valid && !rs_full && dispatch.op != op_nop;
    assign marks_rd = op_writes_rd(dispatch.op) && dispatch.rd != zero_reg;

    always_comb begin
        rs_alloc.busy = accept;
        rs_alloc.op   = dispatch.op;
        rs_alloc.tag  = next_tag;
        rs_alloc.opa  = rename_src(dispatch.rs1, op_uses_rs1(dispatch.op),
                                   rat[dispatch.rs1], cdb);
        rs_alloc.opb  = rename_src(dispatch.rs2, op_uses_rs2(dispatch.op),
                                   rat[dispatch.rs2], cdb);
        rs_alloc.imm  = dispatch.imm;
        rs_alloc.pc   = dispatch.pc;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            next_tag <= first_tag;
            for (int i = 0; i < reg_count; i++) begin
                rat[i].ready   <= 1'b1;
                rat[i].u.value <= '0;
            end
        end else begin
            // results only land where the pending tag still matches
            for (int i = 0; i < reg_count; i++) begin
                rat[i] <= wake_operand(rat[i], cdb);
            end
            if (accept) begin
                if (next_tag == last_tag) begin
                    next_tag <= first_tag;
                end else begin
                    next_tag <= next_tag + 1'b1;
                end
                // newer producer overrides a same-cycle broadcast
                if (marks_rd) begin
                    rat[dispatch.rd].ready      <= 1'b0;
                    rat[dispatch.rd].u.pend.pad <= '0;
                    rat[dispatch.rd].u.pend.tag <= next_tag;
                end
            end
        end
    end

endmodule

//--- reservation_station.sv
`timescale 1ns/1ps

module reservation_station (
    input  logic                     clk,
    input  logic                     rst,
    input  ooo_types_pkg::rs_entry_t rs_alloc,
    input  ooo_types_pkg::cdb_t      cdb,
    output ooo_types_pkg::issue_t    issue,
    output logic                     rs_full
);
    import ooo_types_pkg::*;

    rs_entry_t slot [rs_depth];
    // 0 is the oldest busy slot
    rs_idx_t   rank [rs_depth];

    logic [$clog2(rs_depth+1)-1:0] busy_cnt;

    logic    free_found;
    rs_idx_t free_idx;
    logic    sel_found;
    rs_idx_t sel_idx;
    rs_idx_t new_rank;
    logic    alloc;

    always_comb begin
        busy_cnt   = '0;
        free_found = 1'b0;
        free_idx   = '0;
        sel_found  = 1'b0;
        sel_idx    = '0;
        for (int i = 0; i < rs_depth; i++) begin
            if (slot[i].busy) begin
                busy_cnt = busy_cnt + 1'b1;
            end else if (!free_found) begin
                free_found = 1'b1;
                free_idx   = rs_idx_t'(i);
            end
            // oldest entry with both operands in hand
            if (slot[i].busy && slot[i].opa.ready && slot[i].opb.ready) begin
                if (!sel_found || rank[i] < rank[sel_idx]) begin
                    sel_found = 1'b1;
                    sel_idx   = rs_idx_t'(i);
                end
            end
        end
    end

    assign rs_full  = busy_cnt == rs_depth;
    assign alloc    = rs_alloc.busy && free_found;
    // new entry lands behind everything that stays
    assign new_rank = rs_idx_t'(busy_cnt) - rs_idx_t'(sel_found);

    always_comb begin
        issue.valid = sel_found;
        issue.op    = slot[sel_idx].op;
        issue.tag   = slot[sel_idx].tag;
        issue.a     = slot[sel_idx].opa.u.value;
        issue.b     = slot[sel_idx].opb.u.value;
        issue.imm   = slot[sel_idx].imm;
        issue.pc    = slot[sel_idx].pc;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rs_depth; i++) begin
                slot[i].busy <= 1'b0;
                rank[i]      <= '0;
            end
        end else begin
            for (int i = 0; i < rs_depth; i++) begin
                if (slot[i].busy) begin
                    slot[i].opa <= wake_operand(slot[i].opa, cdb);
                    slot[i].opb <= wake_operand(slot[i].opb, cdb);
                    // younger entries move up past the issued one
                    if (sel_found && rank[i] > rank[sel_idx]) begin
                        rank[i] <= rank[i] - 1'b1;
                    end
                end
            end
            if (sel_found) begin
                slot[sel_idx].busy <= 1'b0;
            end
            if (alloc) begin
                slot[free_idx] <= rs_alloc;
                rank[free_idx] <= new_rank;
            end
        end
    end

endmodule

//--- alu.sv
`timescale 1ns/1ps

module alu (
    input  logic                  clk,
    input  logic                  rst,
    input  ooo_types_pkg::issue_t issue,
    output ooo_types_pkg::cdb_t   cdb
);
    import rv_ops_pkg::*;
    import ooo_types_pkg::*;

    data_t res;
    data_t jaddr;
    logic  jena;
    logic  taken;

    logic [shamt_bits-1:0] sh_b;
    logic [shamt_bits-1:0] sh_i;

    assign sh_b = issue.b[shamt_bits-1:0];
    assign sh_i = issue.imm[shamt_bits-1:0];

    always_comb begin
        res   = '0;
        jena  = 1'b0;
        taken = 1'b0;
        jaddr = issue.pc + pc_step;
        case (issue.op)
            op_add:   res = issue.a + issue.b;
            op_sub:   res = issue.a - issue.b;
            op_and:   res = issue.a & issue.b;
            op_or:    res = issue.a | issue.b;
            op_xor:   res = issue.a ^ issue.b;
            op_sll:   res = issue.a << sh_b;
            op_srl:   res = issue.a >> sh_b;
            op_sra:   res = data_t'($signed(issue.a) >>> sh_b);
            op_sltu:  res = data_t'(issue.a < issue.b);
            op_slt:   res = data_t'($signed(issue.a) < $signed(issue.b));
            op_addi:  res = issue.a + issue.imm;
            op_andi:  res = issue.a & issue.imm;
            op_ori:   res = issue.a | issue.imm;
            op_xori:  res = issue.a ^ issue.imm;
            op_slli:  res = issue.a << sh_i;
            op_srli:  res = issue.a >> sh_i;
            op_srai:  res = data_t'($signed(issue.a) >>> sh_i);
            op_sltiu: res = data_t'(issue.a < issue.imm);
            op_slti:  res = data_t'($signed(issue.a) < $signed(issue.imm));
            op_lui:   res = issue.imm;
            op_auipc: res = issue.pc + issue.imm;
            op_jal: begin
                // fetch already redirected, report the target only
                res   = issue.pc + pc_step;
                jaddr = issue.pc + issue.imm;
            end
            op_jalr: begin
                res   = issue.pc + pc_step;
                jena  = 1'b1;
                jaddr = (issue.a + issue.imm) & ~data_t'(1);
            end
            op_beq:   taken = issue.a == issue.b;
            op_bne:   taken = issue.a != issue.b;
            op_blt:   taken = $signed(issue.a) < $signed(issue.b);
            op_bge:   taken = $signed(issue.a) >= $signed(issue.b);
            op_bltu:  taken = issue.a < issue.b;
            op_bgeu:  taken = issue.a >= issue.b;
            op_lw, op_lhu, op_lh, op_lbu, op_lb,
            op_sw, op_sh, op_sb: begin
                res = issue.a + issue.imm;
            end
            default:  res = '0;
        endcase
        if (op_is_branch(issue.op)) begin
            res  = data_t'(taken);
            jena = taken;
            if (taken) begin
                jaddr = issue.pc + issue.imm;
            end
        end
    end

    // CDB register
    always_ff @(posedge clk) begin
        if (rst) begin
            cdb.valid    <= 1'b0;
            cdb.jump_ena <= 1'b0;
        end else begin
            cdb.valid    <= issue.valid && issue.op != op_nop;
            cdb.jump_ena <= issue.valid && jena;
        end
        cdb.tag       <= issue.valid ? issue.tag : zero_tag;
        cdb.value     <= res;
        cdb.ls_data   <= issue.b;
        cdb.jump_addr <= jaddr;
    end

endmodule

//--- ooo_exec_top.sv
`timescale 1ns/1ps

module ooo_exec_top (
    input  logic                     clk,
    input  logic                     rst,
    input  ooo_types_pkg::dispatch_t dispatch,
    output ooo_types_pkg::cdb_t      cdb,
    output logic                     rs_full
);
    import ooo_types_pkg::*;

    rs_entry_t rs_alloc;
    issue_t    issue;

    dispatch_rename u_rename (
        .clk      (clk),
        .rst      (rst),
        .dispatch (dispatch),
        .cdb      (cdb),
        .rs_full  (rs_full),
        .rs_alloc (rs_alloc)
    );

    reservation_station u_station (
        .clk      (clk),
        .rst      (rst),
        .rs_alloc (rs_alloc),
        .cdb      (cdb),
        .issue    (issue),
        .rs_full  (rs_full)
    );

    // result register doubles as the CDB
    alu u_alu (
        .clk   (clk),
        .rst   (rst),
        .issue (issue),
        .cdb   (cdb)
    );

endmodule

//--- tb_ooo_exec.sv
`timescale 1ns/1ps

module tb_ooo_exec;
    import rv_ops_pkg::*;
    import ooo_types_pkg::*;

    localparam int clk_period  = 20;
    localparam int rst_cycles  = 5;
    localparam int total_instr = 86;

    localparam op_e imm_ops [8] = '{op_lui, op_addi, op_andi, op_ori,
                                    op_xori, op_slti, op_sltiu, op_auipc};
    localparam op_e reg_ops [10] = '{op_add, op_sub, op_and, op_or, op_xor,
                                     op_sll, op_srl, op_sra, op_slt, op_sltu};
    localparam op_e br_ops [6] = '{op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu};
    localparam op_e mem_ops [8] = '{op_lw, op_lhu, op_lh, op_lbu, op_lb, op_sw, op_sh, op_sb};
    // even index taken, odd index not taken, with x5 = -5, x6 = 7, x7 = -5
    localparam reg_idx_t br_rs1 [12] = '{5, 5, 5, 5, 5, 6, 6, 5, 6, 5, 5, 6};
    localparam reg_idx_t br_rs2 [12] = '{7, 6, 6, 7, 6, 5, 5, 6, 5, 6, 6, 5};

    logic      clk;
    logic      rst;
    dispatch_t dispatch;
    cdb_t      cdb;
    logic      rs_full;

    data_t       regs [32];
    cdb_t        exp_q [$];
    int          due_q [$];
    rob_tag_t    tb_tag;
    int          cyc = 0;
    int          checks = 0;
    int          errors = 0;
    logic        full_seen;
    logic [31:0] rng_state = 32'h329b5590;

    ooo_exec_top UUT (.clk(clk), .rst(rst), .dispatch(dispatch),
                      .cdb(cdb), .rs_full(rs_full));

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic data_t imm12();
        logic [31:0] r;
        r = next_rand();
        return {{20{r[11]}}, r[11:0]};
    endfunction

    function automatic data_t imm13();
        logic [31:0] r;
        r = next_rand();
        return {{19{r[12]}}, r[12:1], 1'b0};
    endfunction

    // bit 0 reads rs1, bit 1 reads rs2, by instruction format
    function automatic logic [1:0] src_mask(input op_e op);
        if (op inside {op_nop, op_lui, op_auipc, op_jal}) begin
            return 2'b00;
        end else if (op inside {[op_addi:op_slti], op_jalr}) begin
            return 2'b01;
        end
        return 2'b11;
    endfunction

    function automatic cdb_t predict(input op_e op, input data_t a, input data_t b,
                                     input data_t imm, input data_t pc);
        cdb_t  e;
        data_t sgn;
        logic  take;
        sgn         = 32'h8000_0000;
        take        = 1'b0;
        e           = '0;
        e.valid     = 1'b1;
        e.ls_data   = b;
        e.jump_addr = pc + 4;
        case (op)
            op_add:   e.value = a + b;
            op_sub:   e.value = a + ~b + 1;
            op_and:   e.value = a & b;
            op_or:    e.value = a | b;
            op_xor:   e.value = a ^ b;
            op_sll:   e.value = a << b[4:0];
            op_srl:   e.value = a >> b[4:0];
            op_sra:   e.value = (a >> b[4:0]) | ({32{a[31]}} & ~(32'hffff_ffff >> b[4:0]));
            op_sltu:  e.value = {31'b0, a < b};
            op_slt:   e.value = {31'b0, (a ^ sgn) < (b ^ sgn)};
            op_addi:  e.value = a + imm;
            op_andi:  e.value = a & imm;
            op_ori:   e.value = a | imm;
            op_xori:  e.value = a ^ imm;
            op_sltiu: e.value = {31'b0, a < imm};
            op_slti:  e.value = {31'b0, (a ^ sgn) < (imm ^ sgn)};
            op_lui:   e.value = imm;
            op_auipc: e.value = pc + imm;
            op_jal: begin
                e.value     = pc + 4;
                e.jump_addr = pc + imm;
            end
            op_jalr: begin
                e.value     = pc + 4;
                e.jump_ena  = 1'b1;
                e.jump_addr = (a + imm) & 32'hffff_fffe;
            end
            op_beq:   take = a == b;
            op_bne:   take = a != b;
            op_blt:   take = (a ^ sgn) < (b ^ sgn);
            op_bge:   take = (a ^ sgn) >= (b ^ sgn);
            op_bltu:  take = a < b;
            op_bgeu:  take = a >= b;
            // loads and stores give the address
            default:  e.value = a + imm;
        endcase
        if (op inside {[op_beq:op_bgeu]}) begin
            e.value    = {31'b0, take};
            e.jump_ena = take;
            if (take) begin
                e.jump_addr = pc + imm;
            end
        end
        return e;
    endfunction

    task automatic check_cdb(input cdb_t got, input cdb_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s tag %0d got value %h ls %h jump %b %h, expected %h %h %b %h",
                     $time, what, got.tag, got.value, got.ls_data, got.jump_ena,
                     got.jump_addr, exp.value, exp.ls_data, exp.jump_ena, exp.jump_addr);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // match each broadcast to its outstanding record by tag
    always @(negedge clk) begin : monitor
        int hit;
        hit = -1;
        if (rs_full === 1'b1) begin
            full_seen = 1'b1;
        end
        if (!rst && cdb.valid) begin
            foreach (exp_q[i]) begin
                if (hit < 0 && exp_q[i].tag == cdb.tag) begin
                    hit = i;
                end
            end
            if (hit < 0) begin
                errors++;
                $display("a result with tag %0d matches no waiting instruction", cdb.tag);
            end else begin
                check_cdb(cdb, exp_q[hit], "cdb");
                if (due_q[hit] >= 0 && due_q[hit] != cyc) begin
                    errors++;
                    $display("the result for tag %0d arrived in cycle %0d instead of cycle %0d",
                             cdb.tag, cyc, due_q[hit]);
                end
                exp_q.delete(hit);
                due_q.delete(hit);
            end
        end
    end

    task automatic send(input op_e op, input reg_idx_t rd, input reg_idx_t rs1,
                        input reg_idx_t rs2, input data_t imm, input data_t pc,
                        input logic timed);
        dispatch_t   d;
        cdb_t        e;
        logic [1:0]  src;
        src   = src_mask(op);
        e     = predict(op, src[0] ? regs[rs1] : '0, src[1] ? regs[rs2] : '0, imm, pc);
        e.tag = tb_tag;
        d     = '{valid: 1'b1, op: op, rd: rd, rs1: rs1, rs2: rs2, imm: imm, pc: pc};
        @(posedge clk);
        dispatch <= d;
        @(negedge clk);
        // a full station drops this edge, so keep presenting it
        while (rs_full) begin
            @(negedge clk);
        end
        if (op != op_nop) begin
            exp_q.push_back(e);
            due_q.push_back(timed ? cyc + 2 : -1);
            tb_tag = (tb_tag == 4'd15) ? 4'd1 : tb_tag + 4'd1;
            if (rd != 0 && !(op inside {[op_beq:op_bgeu], op_sw, op_sh, op_sb})) begin
                regs[rd] = e.value;
            end
        end
    endtask

    task automatic idle();
        @(posedge clk);
        dispatch <= '0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        idle();
        while (exp_q.size() != 0 && waited < 100) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            errors += exp_q.size();
            $display("%0d results never appeared on the CDB", exp_q.size());
            exp_q.delete();
            due_q.delete();
        end
    endtask

    task automatic report(input string name);
        $display("test %s finished, %0d errors so far", name, errors);
    endtask

    task automatic test_reset_idle();
        repeat (6) begin
            @(negedge clk);
            check_flag(cdb.valid, 1'b0, "cdb.valid after reset");
            check_flag(cdb.jump_ena, 1'b0, "cdb.jump_ena after reset");
            check_flag(rs_full, 1'b0, "rs_full after reset");
        end
        send(op_nop, 5'd1, 5'd2, 5'd3, '0, '0, 1'b0);
        idle();
        repeat (4) begin
            @(negedge clk);
            check_flag(cdb.valid, 1'b0, "cdb.valid after nop");
        end
        report("reset_idle");
    endtask

    task automatic test_immediates();
        data_t imm;
        for (int i = 0; i < 16; i++) begin
            imm = (imm_ops[i % 8] == op_lui) ? (next_rand() & 32'hffff_f000) : imm12();
            send(imm_ops[i % 8], reg_idx_t'(1 + i % 8), reg_idx_t'(next_rand() % 9), 5'd0,
                 imm, next_rand() & ~32'h3, 1'b1);
            drain();
        end
        report("immediates");
    endtask

    task automatic test_reg_reg();
        send(op_lui, 5'd13, 5'd0, 5'd0, 32'h8765_4000, 32'h100, 1'b0);
        // amount of 2021 keeps only its low five bits
        send(op_addi, 5'd12, 5'd0, 5'd0, 32'h0000_07e5, 32'h104, 1'b0);
        send(op_sra, 5'd11, 5'd13, 5'd12, '0, 32'h108, 1'b0);
        for (int i = 0; i < 20; i++) begin
            send(reg_ops[i % 10], reg_idx_t'(1 + next_rand() % 15),
                 reg_idx_t'(1 + next_rand() % 15), reg_idx_t'(1 + next_rand() % 15),
                 '0, next_rand() & ~32'h3, 1'b0);
        end
        drain();
        report("reg_reg");
    endtask

    task automatic test_chain();
        send(op_addi, 5'd2, 5'd0, 5'd0, imm12(), 32'h200, 1'b0);
        send(op_addi, 5'd1, 5'd0, 5'd0, 32'd3, 32'h204, 1'b0);
        drain();
        full_seen = 1'b0;
        // each add reads the two previous results, x1 x2 x3 in rotation
        for (int i = 0; i < 10; i++) begin
            send(op_add, reg_idx_t'(1 + (i + 2) % 3), reg_idx_t'(1 + i % 3),
                 reg_idx_t'(1 + (i + 1) % 3), '0, 32'h208 + 4 * i, 1'b0);
        end
        drain();
        check_flag(full_seen, 1'b1, "rs_full seen during chain");
        report("chain");
    endtask

    task automatic test_branches();
        send(op_addi, 5'd5, 5'd0, 5'd0, -32'sd5, 32'h300, 1'b0);
        send(op_addi, 5'd6, 5'd0, 5'd0, 32'd7, 32'h304, 1'b0);
        send(op_addi, 5'd7, 5'd0, 5'd0, -32'sd5, 32'h308, 1'b0);
        drain();
        for (int i = 0; i < 12; i++) begin
            send(br_ops[i / 2], 5'd0, br_rs1[i], br_rs2[i], imm13(),
                 next_rand() & ~32'h3, 1'b0);
        end
        send(op_jal, 5'd10, 5'd0, 5'd0, imm13(), next_rand() & ~32'h3, 1'b0);
        send(op_jalr, 5'd11, 5'd6, 5'd0, imm12(), next_rand() & ~32'h3, 1'b0);
        drain();
        report("branches");
    endtask

    task automatic test_load_store();
        send(op_addi, 5'd8, 5'd0, 5'd0, imm12(), 32'h400, 1'b0);
        drain();
        for (int i = 0; i < 8; i++) begin
            // x9 is still pending when the memory op reads it
            send(op_addi, 5'd9, 5'd9, 5'd0, imm12(), 32'h404, 1'b0);
            send(mem_ops[i], 5'd14, 5'd8, 5'd9, imm12(), 32'h408, 1'b0);
        end
        drain();
        report("load_store");
    endtask

    initial begin
        rst       = 1'b1;
        dispatch  = '0;
        tb_tag    = 4'd1;
        full_seen = 1'b0;
        foreach (regs[i]) begin
            regs[i] = '0;
        end
        repeat (rst_cycles) @(posedge clk);
        rst <= 1'b0;
        test_reset_idle();
        test_immediates();
        test_reg_reg();
        test_chain();
        test_branches();
        test_load_store();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        #((rst_cycles + 200 * total_instr) * clk_period);
        $display("simulation timed out before the tests finished");
        $display("Verification failed");
        $finish;
    end

endmodule

//--- all.f
rv_ops_pkg.sv
ooo_types_pkg.sv
dispatch_rename.sv
reservation_station.sv
alu.sv
ooo_exec_top.sv
tb_ooo_exec.sv
